/* all.f */
common/gemm_pkg.sv
source/gemm_bank_fifo.sv
gemm_scheduler/gemm_bank_sweep.sv
gemm_scheduler/gemm_psum_sched.sv
gemm_scheduler/gemm_weight_input_sched.sv
source/gemm_sched_top.sv
sim/gemm_sched_chk.sv
sim/gemm_sched_tb.sv

/* Bender.yml */
package:
  name: gemm_sched

sources:
  - files:
      - common/gemm_pkg.sv
      - source/gemm_bank_fifo.sv
      - gemm_scheduler/gemm_bank_sweep.sv
      - gemm_scheduler/gemm_psum_sched.sv
      - gemm_scheduler/gemm_weight_input_sched.sv
      - source/gemm_sched_top.sv
  - target: simulation
    files:
      - sim/gemm_sched_chk.sv
      - sim/gemm_sched_tb.sv

/* sim/gemm_sched_tb.sv */
module gemm_sched_tb;
    import gemm_pkg::*;

    localparam int NUM_GROUPS     = 60;
    localparam int TIMEOUT_CYCLES = 40 * NUM_GROUPS + 200;
    localparam int CH_PSUM        = 0;
    localparam int CH_WEIGHT      = 1;
    localparam int CH_INPUT       = 2;

    logic                 CLK;
    logic                 nRST;
    logic [NUM_BANKS-1:0] push;
    bank_entry_t          wdata [NUM_BANKS];
    logic [NUM_BANKS-1:0] full;
    logic                 new_weight;
    logic                 drained;
    array_load_t          psum_load;
    array_load_t          weight_load;
    array_load_t          input_load;

    bank_entry_t          model_q [NUM_BANKS][$];  // Rows pushed but not yet delivered.
    logic                 pend_reg;                // Model of the pending-weight flag.
    logic                 nw_seen;
    logic                 wlast_seen;
    logic                 drained_seen;
    logic                 weight_head_seen;
    logic [NUM_BANKS-1:0] full_seen;
    logic                 in_burst [3];
    int                   next_row [3];
    int                   since_reset;
    int                   cycles;

    gemm_sched_top DUT (
        .CLK         (CLK),
        .nRST        (nRST),
        .push        (push),
        .wdata       (wdata),
        .full        (full),
        .new_weight  (new_weight),
        .drained     (drained),
        .psum_load   (psum_load),
        .weight_load (weight_load),
        .input_load  (input_load)
    );

    always #10 CLK = ~CLK;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_load(input string name, input array_load_t got,
                                input array_load_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error t=%0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error t=%0t %s got %b exp %b", $time, name, got, exp));
        end
    endtask

    function automatic mat_t kind_of_channel(input int ch);
        if (ch == CH_PSUM) begin
            return MAT_PSUM;
        end
        return (ch == CH_WEIGHT) ? MAT_WEIGHT : MAT_INPUT;
    endfunction

    function automatic string name_of_channel(input int ch);
        if (ch == CH_PSUM) begin
            return "psum_load";
        end
        return (ch == CH_WEIGHT) ? "weight_load" : "input_load";
    endfunction

    function automatic int groups_left();
        int n;
        n = 0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            n += model_q[i].size();
        end
        return (n + ROWS - 1) / ROWS;
    endfunction

    function automatic logic weight_at_head();
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (model_q[i].size() != 0 && model_q[i][0].kind == MAT_WEIGHT) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // A bank takes a new group only with room for all of its rows.
    function automatic int pick_bank();
        int candidates[$];
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (model_q[i].size() <= FIFO_DEPTH - ROWS && !full_seen[i]) begin
                candidates.push_back(i);
            end
        end
        if (candidates.size() == 0) begin
            return -1;
        end
        return candidates[$urandom % candidates.size()];
    endfunction

    // Checks one strobe channel against the per-bank queues and the burst rules.
    task automatic follow_strobe(input int ch, input array_load_t ld,
                                 input logic pend_before, input logic drained_before);
        int          b;
        bank_entry_t front;
        array_load_t exp;
        string       name;
        name = name_of_channel(ch);
        if (!ld.enable) begin
            if (in_burst[ch]) begin
                report_failure($sformatf("%s burst broke off after %0d rows at time %0t",
                                         name, next_row[ch], $time));
            end
        end
        else begin
            if (!in_burst[ch]) begin
                if (ch != CH_WEIGHT && pend_before) begin
                    report_failure($sformatf(
                        "%s burst started at time %0t while a new weight was pending",
                        name, $time));
                end
                if (ch == CH_WEIGHT && !(pend_before && drained_before)) begin
                    report_failure($sformatf(
                        "weight burst started at time %0t without a pending weight %s",
                        $time, "and a drained array"));
                end
                in_burst[ch] = 1'b1;
                next_row[ch] = 0;
            end
            b = int'(ld.data[47:40]);   // Source bank is encoded in the data word.
            if (b >= NUM_BANKS || model_q[b].size() == 0) begin
                report_failure($sformatf("%s at time %0t carried %h, which was never pushed",
                                         name, $time, ld.data));
            end
            front = model_q[b][0];
            if (front.kind != kind_of_channel(ch)) begin
                report_failure($sformatf("%s at time %0t delivered a group of kind %s",
                                         name, $time, front.kind.name()));
            end
            exp.enable  = 1'b1;
            exp.row_sel = row_t'(next_row[ch]);
            exp.data    = front.data;
            compare_load(name, ld, exp);
            void'(model_q[b].pop_front());
            if (next_row[ch] == ROWS - 1) begin
                in_burst[ch] = 1'b0;
            end
            else begin
                next_row[ch]++;
            end
        end
    endtask

    task automatic drive_array_side(input logic drain);
        if (!new_weight && !pend_reg && weight_head_seen && ($urandom % 2 == 0)) begin
            new_weight <= 1'b1;         // Ask for a weight once one waits at a bank head.
        end
        else begin
            new_weight <= 1'b0;
        end
        if (drain) begin
            drained <= 1'b1;
        end
        else if ($urandom % 8 == 0) begin
            drained <= !drained;
        end
    endtask

    // Outputs are sampled at the falling edge, half a cycle after they settle.
    always @(negedge CLK) begin : monitor
        logic pend_before;
        logic drained_before;
        if (!nRST) begin
            pend_reg     = 1'b1;
            nw_seen      = 1'b0;
            wlast_seen   = 1'b0;
            drained_seen = drained;
            since_reset  = 0;
            for (int ch = 0; ch < 3; ch++) begin
                in_burst[ch] = 1'b0;
                next_row[ch] = 0;
            end
            compare_level("psum_load.enable", psum_load.enable, 1'b0);
            compare_level("weight_load.enable", weight_load.enable, 1'b0);
            compare_level("input_load.enable", input_load.enable, 1'b0);
        end
        else begin
            pend_before    = pend_reg;
            drained_before = drained_seen;
            if (nw_seen) begin
                pend_reg = 1'b1;        // A new weight wins over a finishing weight burst.
            end
            else if (wlast_seen) begin
                pend_reg = 1'b0;
            end
            compare_level("weight_pending", DUT.weight_pending, pend_reg);
            if (since_reset == 0) begin
                compare_level("psum_load.enable", psum_load.enable, 1'b0);
                compare_level("weight_load.enable", weight_load.enable, 1'b0);
                compare_level("input_load.enable", input_load.enable, 1'b0);
            end
            since_reset++;
            // A row pushed in this cycle is stored only at the next edge.
            for (int i = 0; i < NUM_BANKS; i++) begin
                compare_level($sformatf("full[%0d]", i), full[i],
                              (model_q[i].size() - int'(push[i])) == FIFO_DEPTH);
            end
            follow_strobe(CH_PSUM, psum_load, pend_before, drained_before);
            follow_strobe(CH_WEIGHT, weight_load, pend_before, drained_before);
            follow_strobe(CH_INPUT, input_load, pend_before, drained_before);
            nw_seen      = new_weight;
            wlast_seen   = weight_load.enable && (weight_load.row_sel == row_t'(ROWS - 1));
            drained_seen = drained;
        end
        full_seen        = full;
        weight_head_seen = weight_at_head();
    end

    always @(posedge CLK) begin : watchdog
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            report_failure($sformatf(
                "timeout after %0d cycles, %0d pushed groups were never delivered",
                cycles, groups_left()));
        end
    end

    initial begin : stimulus
        int          group;
        int          row;
        int          gap;
        int          bank;
        mat_t        kind;
        bank_entry_t e;
        void'($urandom(32'h6275));
        CLK              = 1'b0;
        nRST             = 1'b0;
        push             = '0;
        new_weight       = 1'b0;
        drained          = 1'b1;
        cycles           = 0;
        full_seen        = '0;
        weight_head_seen = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            wdata[i] = '0;
        end
        group = 0;
        row   = 0;
        gap   = 0;
        bank  = -1;
        kind  = MAT_WEIGHT;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        while (group < NUM_GROUPS || groups_left() != 0) begin
            @(posedge CLK);
            drive_array_side(group >= NUM_GROUPS);
            push <= '0;
            if (group < NUM_GROUPS) begin
                if (row == 0 && gap > 0) begin
                    gap--;
                end
                else begin
                    if (row == 0) begin
                        bank = pick_bank();
                        // The array starts without a weight, so the first group brings one.
                        kind = (group == 0) ? MAT_WEIGHT : mat_t'(1 + $urandom % 3);
                    end
                    if (bank >= 0) begin
                        e.kind = kind;
                        e.data = {16'hC0DE, 8'(bank), 8'(kind), 16'(group), 16'(row)};
                        push[bank]  <= 1'b1;
                        wdata[bank] <= e;
                        model_q[bank].push_back(e);
                        if (row == ROWS - 1) begin
                            row   = 0;
                            group = group + 1;
                            gap   = $urandom % 3;
                        end
                        else begin
                            row = row + 1;
                        end
                    end
                end
            end
        end
        @(posedge CLK);
        new_weight <= 1'b0;
        repeat (10) @(posedge CLK);     // Any stray strobe now has no queued row to match.
        $display("TEST OK");
        $finish;
    end

endmodule

/* sim/gemm_sched_chk.sv */
module gemm_sched_chk (
    input logic                           CLK,
    input logic                           nRST,
    input gemm_pkg::bank_view_t           views [gemm_pkg::NUM_BANKS],
    input logic [gemm_pkg::NUM_BANKS-1:0] pop,
    input gemm_pkg::array_load_t          psum_load,
    input gemm_pkg::array_load_t          weight_load,
    input gemm_pkg::array_load_t          input_load
);
    import gemm_pkg::*;

    // Weight and input share one sweep, so only one of them loads at a time.
    wi_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(weight_load.enable && input_load.enable))
        else $error("weight and input strobes are active in the same cycle");

    psum_row_step: assert property (@(posedge CLK) disable iff (!nRST)
        psum_load.enable && (psum_load.row_sel != row_t'(ROWS - 1)) |=>
            psum_load.enable && (psum_load.row_sel == row_t'($past(psum_load.row_sel) + 1)))
        else $error("psum burst row number did not step by one");

    weight_row_step: assert property (@(posedge CLK) disable iff (!nRST)
        weight_load.enable && (weight_load.row_sel != row_t'(ROWS - 1)) |=>
            weight_load.enable && (weight_load.row_sel == row_t'($past(weight_load.row_sel) + 1)))
        else $error("weight burst row number did not step by one");

    input_row_step: assert property (@(posedge CLK) disable iff (!nRST)
        input_load.enable && (input_load.row_sel != row_t'(ROWS - 1)) |=>
            input_load.enable && (input_load.row_sel == row_t'($past(input_load.row_sel) + 1)))
        else $error("input burst row number did not step by one");

    // A burst on a bank begins where its pop rises.
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_pop
        pop_whole_group: assert property (@(posedge CLK) disable iff (!nRST)
            $rose(pop[i]) |-> views[i].group_ready)
            else $error("bank %0d burst began without a whole group stored", i);
    end

endmodule

bind gemm_sched_top gemm_sched_chk u_chk (
    .CLK         (CLK),
    .nRST        (nRST),
    .views       (views),
    .pop         (pop),
    .psum_load   (psum_load),
    .weight_load (weight_load),
    .input_load  (input_load)
);

/* source/gemm_sched_top.sv */
module gemm_sched_top (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [gemm_pkg::NUM_BANKS-1:0] push,
    input  gemm_pkg::bank_entry_t          wdata [gemm_pkg::NUM_BANKS],
    output logic [gemm_pkg::NUM_BANKS-1:0] full,
    input  logic                           new_weight,
    input  logic                           drained,
    output gemm_pkg::array_load_t          psum_load,
    output gemm_pkg::array_load_t          weight_load,
    output gemm_pkg::array_load_t          input_load
);
    import gemm_pkg::*;

    bank_view_t           views [NUM_BANKS];
    logic [NUM_BANKS-1:0] psum_pop;
    logic [NUM_BANKS-1:0] wi_pop;
    logic [NUM_BANKS-1:0] pop;
    logic                 weight_pending;

    // Each side only claims heads of its own kind, so the two never pop one bank.
    assign pop = psum_pop | wi_pop;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        gemm_bank_fifo u_fifo (
            .CLK   (CLK),
            .nRST  (nRST),
            .push  (push[i]),
            .wdata (wdata[i]),
            .pop   (pop[i]),
            .view  (views[i]),
            .full  (full[i])
        );
    end

    gemm_psum_sched u_psum_sched (
        .CLK            (CLK),
        .nRST           (nRST),
        .views          (views),
        .weight_pending (weight_pending),
        .psum_load      (psum_load),
        .pop            (psum_pop)
    );

    // Owns the pending-weight flag that also holds back the partial sums.
    gemm_weight_input_sched u_wi_sched (
        .CLK            (CLK),
        .nRST           (nRST),
        .views          (views),
        .new_weight     (new_weight),
        .drained        (drained),
        .weight_pending (weight_pending),
        .weight_load    (weight_load),
        .input_load     (input_load),
        .pop            (wi_pop)
    );

endmodule

/* gemm_scheduler/gemm_weight_input_sched.sv */
module gemm_weight_input_sched (
    input  logic                           CLK,
    input  logic                           nRST,
    input  gemm_pkg::bank_view_t           views [gemm_pkg::NUM_BANKS],
    input  logic                           new_weight,
    input  logic                           drained,
    output logic                           weight_pending,
    output gemm_pkg::array_load_t          weight_load,
    output gemm_pkg::array_load_t          input_load,
    output logic [gemm_pkg::NUM_BANKS-1:0] pop
);
    import gemm_pkg::*;

    logic [NUM_BANKS-1:0] match;
    logic                 busy;
    logic                 last;
    logic                 stall;
    logic                 weight_done;
    logic                 n_weight_pending;
    mat_t                 want_kind;
    bank_t                bank;
    row_t                 row;
    bank_entry_t          claimed;

    // While a weight is owed only weight groups are taken, inputs otherwise.
    assign want_kind = weight_pending ? MAT_WEIGHT : MAT_INPUT;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            match[i] = views[i].group_ready && (views[i].head.kind == want_kind);
        end
    end

    // The array has to drain before a new weight can be shifted in.
    assign stall = weight_pending && !drained;

    gemm_bank_sweep u_sweep (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (stall),
        .match (match),
        .busy  (busy),
        .bank  (bank),
        .row   (row),
        .last  (last)
    );

    assign claimed     = views[bank].head;
    assign weight_done = last && (claimed.kind == MAT_WEIGHT);

    // A fresh new_weight wins over the clear from a finishing weight burst.
    always_comb begin
        n_weight_pending = weight_pending;
        if (new_weight) begin
            n_weight_pending = 1'b1;
        end
        else if (weight_done) begin
            n_weight_pending = 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (nRST == 1'b0) begin
            weight_pending <= 1'b1;     // The array starts without a weight.
        end
        else begin
            weight_pending <= n_weight_pending;
        end
    end

    // The claimed group's own kind picks the strobe for the whole burst.
    always_comb begin
        weight_load = '0;
        input_load  = '0;
        pop         = '0;
        if (busy) begin
            pop[bank] = 1'b1;
            if (claimed.kind == MAT_WEIGHT) begin
                weight_load.enable  = 1'b1;
                weight_load.row_sel = row;
                weight_load.data    = claimed.data;
            end
            else begin
                input_load.enable  = 1'b1;
                input_load.row_sel = row;
                input_load.data    = claimed.data;
            end
        end
    end

endmodule

/* gemm_scheduler/gemm_psum_sched.sv */
module gemm_psum_sched (
    input  logic                           CLK,
    input  logic                           nRST,
    input  gemm_pkg::bank_view_t           views [gemm_pkg::NUM_BANKS],
    input  logic                           weight_pending,
    output gemm_pkg::array_load_t          psum_load,
    output logic [gemm_pkg::NUM_BANKS-1:0] pop
);
    import gemm_pkg::*;

    logic [NUM_BANKS-1:0] match;
    logic                 busy;
    bank_t                bank;
    row_t                 row;

    // A bank is eligible only with a whole partial-sum group at its head.
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            match[i] = views[i].group_ready && (views[i].head.kind == MAT_PSUM);
        end
    end

    // Partial sums wait as long as a new weight is still owed to the array.
    gemm_bank_sweep u_sweep (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (weight_pending),
        .match (match),
        .busy  (busy),
        .bank  (bank),
        .row   (row),
        .last  ()
    );

    always_comb begin
        psum_load = '0;
        pop       = '0;
        if (busy) begin
            psum_load.enable  = 1'b1;
            psum_load.row_sel = row;
            psum_load.data    = views[bank].head.data;
            pop[bank]         = 1'b1;   // Each row is consumed as it goes out.
        end
    end

endmodule

/* gemm_scheduler/gemm_bank_sweep.sv */
module gemm_bank_sweep (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           stall,
    input  logic [gemm_pkg::NUM_BANKS-1:0] match,
    output logic                           busy,
    output gemm_pkg::bank_t                bank,
    output gemm_pkg::row_t                 row,
    output logic                           last
);
    import gemm_pkg::*;

    typedef enum logic [1:0] {
        SWEEP_STALL,
        SWEEP_CHECK,
        SWEEP_BURST
    } sweep_state_t;

    sweep_state_t state, n_state;
    bank_t        n_bank, bank_inc;
    row_t         n_row;

    assign busy = (state == SWEEP_BURST);
    assign last = busy && (row == row_t'(ROWS - 1));

    assign bank_inc = (bank == bank_t'(NUM_BANKS - 1)) ? '0 : bank + 1'b1;

    always_ff @(posedge CLK, negedge nRST) begin
        if (nRST == 1'b0) begin
            state <= SWEEP_STALL;
            bank  <= '0;
            row   <= '0;
        end
        else begin
            state <= n_state;
            bank  <= n_bank;
            row   <= n_row;
        end
    end

    always_comb begin
        n_state = state;
        n_bank  = bank;
        n_row   = row;
        case (state)
            SWEEP_STALL: begin
                n_bank = '0;                    // Every restart begins at bank 0.
                if (!stall) begin
                    n_state = SWEEP_CHECK;
                end
            end
            SWEEP_CHECK: begin
                if (stall) begin
                    n_state = SWEEP_STALL;
                end
                else if (match[bank]) begin
                    n_state = SWEEP_BURST;      // Bank is held for the whole burst.
                    n_row   = '0;
                end
                else begin
                    n_bank = bank_inc;
                end
            end
            SWEEP_BURST: begin
                // Stall is not looked at here, a burst always runs to its end.
                if (last) begin
                    n_state = SWEEP_CHECK;
                    n_bank  = bank_inc;
                    n_row   = '0;
                end
                else begin
                    n_row = row + 1'b1;
                end
            end
            default: begin
                n_state = SWEEP_STALL;
            end
        endcase
    end

endmodule

/* source/gemm_bank_fifo.sv */
module gemm_bank_fifo (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  push,
    input  gemm_pkg::bank_entry_t wdata,
    input  logic                  pop,
    output gemm_pkg::bank_view_t  view,
    output logic                  full
);
    import gemm_pkg::*;

    bank_entry_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W-1:0] n_wr_ptr, n_rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en, rd_en;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign wr_en = push && !full;           // A push into a full bank is dropped.
    assign rd_en = pop && (count != '0);

    // Pointers wrap explicitly so the depth need not be a power of two.
    assign n_wr_ptr = (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign n_rd_ptr = (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (nRST == 1'b0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (wr_en) begin
                wr_ptr <= n_wr_ptr;
            end
            if (rd_en) begin
                rd_ptr <= n_rd_ptr;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle, or push and pop together.
            endcase
        end
    end

    // Groups are pushed and popped whole, so the head always starts a group.
    assign view.group_ready = (count >= CNT_W'(ROWS));
    assign view.head        = mem[rd_ptr];

endmodule

/* common/gemm_pkg.sv */
package gemm_pkg;

    // Array and bank geometry.
    localparam int NUM_BANKS  = 4;
    localparam int ROWS       = 4;  // Rows per group, and per burst toward the array.
    localparam int DATA_W     = 64;
    localparam int FIFO_DEPTH = 8;  // Entries per bank, room for two whole groups.

    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int ROW_W  = $clog2(ROWS);
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);  // Count reaches FIFO_DEPTH itself.

    // Matrix type carried by every bank entry.
    typedef enum logic [1:0] {
        MAT_NONE   = 2'd0,
        MAT_INPUT  = 2'd1,
        MAT_WEIGHT = 2'd2,
        MAT_PSUM   = 2'd3
    } mat_t;

    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [ROW_W-1:0]  row_t;

    // One stored row of a bank.
    typedef struct packed {
        mat_t              kind;
        logic [DATA_W-1:0] data;
    } bank_entry_t;

    // What a scheduler sees of one bank.
    typedef struct packed {
        logic        group_ready;  // At least one whole group is stored.
        bank_entry_t head;         // Oldest entry, only meaningful when not empty.
    } bank_view_t;

    // One load strobe toward the systolic array.
    typedef struct packed {
        logic              enable;
        row_t              row_sel;
        logic [DATA_W-1:0] data;
    } array_load_t;

endpackage
